/* hw/rab_defines.svh */
// ####################################################################
// width and size macros shared by the rab_lite RTL and testbench
// RAB_CFG_ADDR_W must cover RAB_N_SLICES * 4 configuration words
// the address path assumes an 8 byte data bus
// ####################################################################

`ifndef RAB_DEFINES_SVH
`define RAB_DEFINES_SVH

`define RAB_N_SLICES       4    // translation slices
`define RAB_VADDR_W        32   // virtual (input) address
`define RAB_PADDR_W        40   // physical (output) address
`define RAB_CFG_W          64   // configuration word
`define RAB_CFG_ADDR_W     4    // slice * 4 + word

// log2 of the data bus width in bytes
`define RAB_BUS_BYTES_LOG2 3

`endif

/* hw/rab_pkg.sv */
// ####################################################################
// address, burst and slice configuration types of rab_lite
// a slice covers the inclusive range start_addr .. end_addr
// ####################################################################

`include "rab_defines.svh"

package rab_pkg;

  typedef logic [`RAB_VADDR_W-1:0] vaddr_t;
  typedef logic [`RAB_PADDR_W-1:0] paddr_t;
  typedef logic [`RAB_CFG_W-1:0]   cfg_word_t;

  typedef logic [7:0] burst_len_t;   // beats minus one
  typedef logic [2:0] burst_size_t;  // log2 of bytes per beat

  // config word 3, bit 0 is enable
  typedef struct packed {
    logic coherent;  // bit 3
    logic wr_en;     // bit 2
    logic rd_en;     // bit 1
    logic en;        // bit 0
  } slice_flags_t;

  typedef struct packed {
    vaddr_t       start_addr;  // word 0
    vaddr_t       end_addr;    // word 1, inclusive
    paddr_t       offset;      // word 2, physical base of the slice
    slice_flags_t flags;       // word 3
  } slice_cfg_t;

  typedef slice_cfg_t [`RAB_N_SLICES-1:0] slice_cfg_arr_t;

endpackage

/* hw/rab_cfg_regs.sv */
// ####################################################################
// slice configuration registers, written by a one cycle strobe
// word address = slice * 4 + word, no read back path
// upper bits of a word beyond its field are dropped
// all slices come out of reset disabled
// ####################################################################

`timescale 1ns/100ps
`include "rab_defines.svh"

module rab_cfg_regs
(
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  logic                       cfg_wen,
  input  logic [`RAB_CFG_ADDR_W-1:0] cfg_addr,
  input  rab_pkg::cfg_word_t         cfg_wdata,
  output rab_pkg::slice_cfg_arr_t    slice_cfg
);

  import rab_pkg::*;

  localparam int SLICE_IDX_W = `RAB_CFG_ADDR_W - 2;

  slice_cfg_arr_t           cfg_q;
  logic [SLICE_IDX_W-1:0]   slice_idx;
  logic [1:0]               word_idx;
  logic [`RAB_N_SLICES-1:0] slice_wen;  // one hot write select

  assign slice_idx = cfg_addr[`RAB_CFG_ADDR_W-1:2];
  assign word_idx  = cfg_addr[1:0];

  always_comb
  begin
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      slice_wen[s] = cfg_wen && (slice_idx == SLICE_IDX_W'(s));
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      cfg_q <= '0;
    end
    else
    begin
      for (int s = 0; s < `RAB_N_SLICES; s++)
      begin
        if (slice_wen[s])
        begin
          // truncate the word into its field
          case (word_idx)
            2'd0:    cfg_q[s].start_addr <= cfg_wdata[`RAB_VADDR_W-1:0];
            2'd1:    cfg_q[s].end_addr   <= cfg_wdata[`RAB_VADDR_W-1:0];
            2'd2:    cfg_q[s].offset     <= cfg_wdata[`RAB_PADDR_W-1:0];
            default: cfg_q[s].flags      <= slice_flags_t'(cfg_wdata[3:0]);
          endcase
        end
      end
    end
  end

  // lookups see a write from the following cycle on
  assign slice_cfg = cfg_q;

endmodule

/* hw/rab_req_arb.sv */
// ####################################################################
// request side: round robin between the two channels and the byte
// range of the selected burst
// requests are levels and must stay stable until accept or drop
// priority moves only on a served pulse, channel 1 first after reset
// address wrap past the top of the space is not handled
// ####################################################################

`timescale 1ns/100ps
`include "rab_defines.svh"

module rab_req_arb
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  rab_pkg::vaddr_t      c1_addr,
  input  rab_pkg::burst_len_t  c1_len,
  input  rab_pkg::burst_size_t c1_size,
  input  logic                 c1_type,
  input  logic                 c1_addr_valid,
  input  rab_pkg::vaddr_t      c2_addr,
  input  rab_pkg::burst_len_t  c2_len,
  input  rab_pkg::burst_size_t c2_size,
  input  logic                 c2_type,
  input  logic                 c2_addr_valid,
  input  logic                 served,
  input  logic                 served_c1,
  output logic                 req_valid,
  output logic                 sel_c1,
  output logic                 rw,
  output rab_pkg::vaddr_t      addr_min,
  output rab_pkg::vaddr_t      addr_max
);

  import rab_pkg::*;

  localparam int LSB_W = `RAB_BUS_BYTES_LOG2;

  logic             prio_c1;  // 1 favors channel 1
  vaddr_t           req_addr;
  burst_len_t       req_len;
  burst_size_t      req_size;
  logic [LSB_W-1:0] lsb_mask;
  vaddr_t           align_addr;
  vaddr_t           burst_bytes;

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      prio_c1 <= 1'b1;
    else if (served)
      prio_c1 <= ~served_c1;  // hand over to the other channel
  end

  assign req_valid = c1_addr_valid | c2_addr_valid;
  assign sel_c1    = (prio_c1 & c1_addr_valid) | ~c2_addr_valid;

  assign req_addr = sel_c1 ? c1_addr : c2_addr;
  assign req_len  = sel_c1 ? c1_len  : c2_len;
  assign req_size = sel_c1 ? c1_size : c2_size;
  assign rw       = sel_c1 ? c1_type : c2_type;  // 1 = write

  // align the start to the beat size before computing the end
  always_comb
  begin
    if (req_size <= burst_size_t'(LSB_W))
      lsb_mask = {LSB_W{1'b1}} << req_size;
    else
      lsb_mask = '0;  // beats wider than the bus
  end

  assign align_addr  = {req_addr[`RAB_VADDR_W-1:LSB_W], req_addr[LSB_W-1:0] & lsb_mask};
  assign burst_bytes = (vaddr_t'(req_len) + vaddr_t'(1)) << req_size;

  assign addr_min = req_addr;
  assign addr_max = align_addr + burst_bytes - vaddr_t'(1);  // last byte of the burst

endmodule

/* hw/rab_slice_array.sv */
// ####################################################################
// slice lookup, purely combinational from the configuration
// a slice hits only if the whole burst range lies inside it
// with several hits the lowest slice drives out_addr and coherent,
// the response side drops such requests anyway
// ####################################################################

`timescale 1ns/100ps
`include "rab_defines.svh"

module rab_slice_array
(
  input  rab_pkg::slice_cfg_arr_t slice_cfg,
  input  logic                    rw,
  input  rab_pkg::vaddr_t         addr_min,
  input  rab_pkg::vaddr_t         addr_max,
  output logic                    hit,
  output logic                    multi_hit,
  output logic                    prot,
  output logic                    coherent,
  output rab_pkg::paddr_t         out_addr
);

  import rab_pkg::*;

  logic   [`RAB_N_SLICES-1:0] slice_hit;
  logic   [`RAB_N_SLICES-1:0] slice_prot;
  vaddr_t [`RAB_N_SLICES-1:0] slice_dist;  // distance from slice start
  paddr_t [`RAB_N_SLICES-1:0] slice_addr;

  // per slice compare and translation
  always_comb
  begin
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      slice_hit[s] = slice_cfg[s].flags.en &&
                     (slice_cfg[s].start_addr <= addr_min) &&
                     (addr_max <= slice_cfg[s].end_addr);

      // direction not allowed in a hitting slice
      slice_prot[s] = slice_hit[s] &&
                      (rw ? !slice_cfg[s].flags.wr_en : !slice_cfg[s].flags.rd_en);

      slice_dist[s] = addr_min - slice_cfg[s].start_addr;
      slice_addr[s] = slice_cfg[s].offset + paddr_t'(slice_dist[s]);
    end
  end

  // pick the lowest hitting slice, flag any further hit
  always_comb
  begin
    hit       = 1'b0;
    multi_hit = 1'b0;
    coherent  = 1'b0;
    out_addr  = '0;
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      if (slice_hit[s])
      begin
        if (hit)
        begin
          multi_hit = 1'b1;
        end
        else
        begin
          out_addr = slice_addr[s];
          coherent = slice_cfg[s].flags.coherent;
        end
        hit = 1'b1;
      end
    end
  end

  assign prot = |slice_prot;

endmodule

/* hw/rab_resp_fsm.sv */
// ####################################################################
// response FSM: accept, drop or miss per request, one pulse each
// a request seen in IDLE at edge k is answered from edge k to k+1
// after an accept nothing is evaluated until that channel's sent
// after a drop one HOLD cycle lets the requester take valid away
// out_addr and cache_coherent hold until the next accept
// ####################################################################

`timescale 1ns/100ps

module rab_resp_fsm
(
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  input  logic            req_valid,
  input  logic            sel_c1,
  input  logic            c1_sent,
  input  logic            c2_sent,
  input  logic            hit,
  input  logic            multi_hit,
  input  logic            prot,
  input  logic            coherent,
  input  rab_pkg::paddr_t lookup_addr,
  output logic            c1_accept,
  output logic            c1_drop,
  output logic            c1_miss,
  output logic            c2_accept,
  output logic            c2_drop,
  output logic            c2_miss,
  output logic            served,
  output logic            served_c1,
  output logic            cache_coherent,
  output logic            int_miss,
  output logic            int_prot,
  output logic            int_multi,
  output rab_pkg::paddr_t out_addr
);

  typedef enum logic [1:0] {IDLE, WAIT_SENT, HOLD} state_t;

  state_t state_q;
  logic   acc_c1_q;  // channel that got the last accept
  logic   drop_d;
  logic   miss_d;
  logic   prot_d;
  logic   multi_d;

  // decision in priority order
  always_comb
  begin
    drop_d  = 1'b1;
    miss_d  = 1'b0;
    prot_d  = 1'b0;
    multi_d = 1'b0;
    if (multi_hit)
      multi_d = 1'b1;
    else if (!hit)
      miss_d = 1'b1;
    else if (prot)
      prot_d = 1'b1;
    else
      drop_d = 1'b0;  // clean single hit
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q        <= IDLE;
      acc_c1_q       <= 1'b1;
      c1_accept      <= 1'b0;
      c1_drop        <= 1'b0;
      c1_miss        <= 1'b0;
      c2_accept      <= 1'b0;
      c2_drop        <= 1'b0;
      c2_miss        <= 1'b0;
      int_miss       <= 1'b0;
      int_prot       <= 1'b0;
      int_multi      <= 1'b0;
      out_addr       <= '0;
      cache_coherent <= 1'b0;
    end
    else
    begin
      // pulses fall back after one cycle
      c1_accept <= 1'b0;
      c1_drop   <= 1'b0;
      c1_miss   <= 1'b0;
      c2_accept <= 1'b0;
      c2_drop   <= 1'b0;
      c2_miss   <= 1'b0;
      int_miss  <= 1'b0;
      int_prot  <= 1'b0;
      int_multi <= 1'b0;

      case (state_q)
        IDLE:
        begin
          if (req_valid)
          begin
            c1_accept <= sel_c1 & ~drop_d;
            c2_accept <= ~sel_c1 & ~drop_d;
            c1_drop   <= sel_c1 & drop_d;
            c2_drop   <= ~sel_c1 & drop_d;
            c1_miss   <= sel_c1 & miss_d;
            c2_miss   <= ~sel_c1 & miss_d;
            int_miss  <= miss_d;
            int_prot  <= prot_d;
            int_multi <= multi_d;
            if (drop_d)
            begin
              state_q <= HOLD;
            end
            else
            begin
              state_q        <= WAIT_SENT;
              acc_c1_q       <= sel_c1;
              out_addr       <= lookup_addr;
              cache_coherent <= coherent;
            end
          end
        end
        WAIT_SENT:
        begin
          if (acc_c1_q ? c1_sent : c2_sent)
            state_q <= IDLE;
        end
        default:
        begin
          state_q <= IDLE;  // HOLD, inputs ignored
        end
      endcase
    end
  end

  // moves the arbiter priority
  assign served    = c1_accept | c1_drop | c2_accept | c2_drop;
  assign served_c1 = c1_accept | c1_drop;

endmodule

/* hw/rab_lite_top.sv */
// ####################################################################
// rab_lite: one remapping port with two request channels, four
// slices and a strobe written configuration
// channel signals are levels plus accept/drop/miss/sent strobes
// ####################################################################

`timescale 1ns/100ps
`include "rab_defines.svh"

module rab_lite_top
(
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  logic                       cfg_wen,
  input  logic [`RAB_CFG_ADDR_W-1:0] cfg_addr,
  input  rab_pkg::cfg_word_t         cfg_wdata,
  input  rab_pkg::vaddr_t            c1_addr,
  input  rab_pkg::burst_len_t        c1_len,
  input  rab_pkg::burst_size_t       c1_size,
  input  logic                       c1_type,
  input  logic                       c1_addr_valid,
  input  logic                       c1_sent,
  output logic                       c1_accept,
  output logic                       c1_drop,
  output logic                       c1_miss,
  input  rab_pkg::vaddr_t            c2_addr,
  input  rab_pkg::burst_len_t        c2_len,
  input  rab_pkg::burst_size_t       c2_size,
  input  logic                       c2_type,
  input  logic                       c2_addr_valid,
  input  logic                       c2_sent,
  output logic                       c2_accept,
  output logic                       c2_drop,
  output logic                       c2_miss,
  output rab_pkg::paddr_t            out_addr,
  output logic                       cache_coherent,
  output logic                       int_miss,
  output logic                       int_prot,
  output logic                       int_multi
);

  import rab_pkg::*;

  slice_cfg_arr_t slice_cfg;
  logic           req_valid;
  logic           sel_c1;
  logic           rw;
  vaddr_t         addr_min;
  vaddr_t         addr_max;
  logic           hit;
  logic           multi_hit;
  logic           prot;
  logic           coherent;
  paddr_t         lookup_addr;  // combinational translation
  logic           served;
  logic           served_c1;

  rab_cfg_regs u_cfg_regs
  (
    .Clk_CI    ( Clk_CI    ),
    .Rst_RBI   ( Rst_RBI   ),
    .cfg_wen   ( cfg_wen   ),
    .cfg_addr  ( cfg_addr  ),
    .cfg_wdata ( cfg_wdata ),
    .slice_cfg ( slice_cfg )
  );

  rab_req_arb u_req_arb
  (
    .Clk_CI        ( Clk_CI        ),
    .Rst_RBI       ( Rst_RBI       ),
    .c1_addr       ( c1_addr       ),
    .c1_len        ( c1_len        ),
    .c1_size       ( c1_size       ),
    .c1_type       ( c1_type       ),
    .c1_addr_valid ( c1_addr_valid ),
    .c2_addr       ( c2_addr       ),
    .c2_len        ( c2_len        ),
    .c2_size       ( c2_size       ),
    .c2_type       ( c2_type       ),
    .c2_addr_valid ( c2_addr_valid ),
    .served        ( served        ),
    .served_c1     ( served_c1     ),
    .req_valid     ( req_valid     ),
    .sel_c1        ( sel_c1        ),
    .rw            ( rw            ),
    .addr_min      ( addr_min      ),
    .addr_max      ( addr_max      )
  );

  rab_slice_array u_slice_array
  (
    .slice_cfg ( slice_cfg   ),
    .rw        ( rw          ),
    .addr_min  ( addr_min    ),
    .addr_max  ( addr_max    ),
    .hit       ( hit         ),
    .multi_hit ( multi_hit   ),
    .prot      ( prot        ),
    .coherent  ( coherent    ),
    .out_addr  ( lookup_addr )
  );

  rab_resp_fsm u_resp_fsm
  (
    .Clk_CI         ( Clk_CI         ),
    .Rst_RBI        ( Rst_RBI        ),
    .req_valid      ( req_valid      ),
    .sel_c1         ( sel_c1         ),
    .c1_sent        ( c1_sent        ),
    .c2_sent        ( c2_sent        ),
    .hit            ( hit            ),
    .multi_hit      ( multi_hit      ),
    .prot           ( prot           ),
    .coherent       ( coherent       ),
    .lookup_addr    ( lookup_addr    ),
    .c1_accept      ( c1_accept      ),
    .c1_drop        ( c1_drop        ),
    .c1_miss        ( c1_miss        ),
    .c2_accept      ( c2_accept      ),
    .c2_drop        ( c2_drop        ),
    .c2_miss        ( c2_miss        ),
    .served         ( served         ),
    .served_c1      ( served_c1      ),
    .cache_coherent ( cache_coherent ),
    .int_miss       ( int_miss       ),
    .int_prot       ( int_prot       ),
    .int_multi      ( int_multi      ),
    .out_addr       ( out_addr       )
  );

endmodule

/* tb/rab_lite_chk.sv */
// ####################################################################
// response protocol checks, bound into rab_resp_fsm
// checks are off while reset is asserted
// ####################################################################

`timescale 1ns/100ps

module rab_lite_chk
(
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic c1_accept,
  input logic c1_drop,
  input logic c1_miss,
  input logic c2_accept,
  input logic c2_drop,
  input logic c2_miss,
  input logic int_miss,
  input logic int_prot,
  input logic int_multi
);

  logic any_drop;
  logic any_resp;

  assign any_drop = c1_drop | c2_drop;
  assign any_resp = any_drop | c1_accept | c2_accept;

  // only one response strobe at a time
  one_resp_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    $onehot0({c1_accept, c1_drop, c2_accept, c2_drop}))
    else $error("more than one accept or drop strobe in one cycle");

  miss_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (c1_miss -> c1_drop) && (c2_miss -> c2_drop))
    else $error("miss without drop on the same channel");

  irq_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (int_miss | int_prot | int_multi) |-> any_drop)
    else $error("interrupt pulse without a drop");

  // HOLD cycle after every drop
  hold_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    any_drop |=> !any_resp)
    else $error("response in the cycle after a drop");

endmodule

/* tb/rab_lite_tb.sv */
// ####################################################################
// testbench for rab_lite_top with a slice setup and a table of requests
// rows with channel 3 drive both channels at once
// stops at the first wrong response
// ####################################################################

`timescale 1ns/100ps
`include "rab_defines.svh"

module rab_lite_tb;

  import rab_pkg::*;

  localparam int N_ROWS     = 10;
  localparam int CLK_PERIOD = 20;
  localparam logic [1:0] R_ACC   = 2'd0;
  localparam logic [1:0] R_PROT  = 2'd1;
  localparam logic [1:0] R_MISS  = 2'd2;
  localparam logic [1:0] R_MULTI = 2'd3;

  logic Clk_CI, Rst_RBI, cfg_wen;
  logic [`RAB_CFG_ADDR_W-1:0] cfg_addr;
  cfg_word_t cfg_wdata;
  vaddr_t c1_addr, c2_addr;
  burst_len_t c1_len, c2_len;
  burst_size_t c1_size, c2_size;
  logic c1_type, c1_addr_valid, c1_sent, c1_accept, c1_drop, c1_miss;
  logic c2_type, c2_addr_valid, c2_sent, c2_accept, c2_drop, c2_miss;
  paddr_t out_addr;
  logic cache_coherent, int_miss, int_prot, int_multi;

  // stimulus table
  string       row_name [N_ROWS];
  logic [1:0]  row_chan [N_ROWS];  // 1, 2 or 3 for both
  vaddr_t      row_base [N_ROWS];
  vaddr_t      row_span [N_ROWS];  // 0 = fixed address
  burst_len_t  row_len  [N_ROWS];
  burst_size_t row_size [N_ROWS];
  logic        row_type [N_ROWS];
  logic [1:0]  row_exp  [N_ROWS];

  // reference copy of the slice setup
  vaddr_t     s_start [`RAB_N_SLICES];
  vaddr_t     s_end   [`RAB_N_SLICES];
  paddr_t     s_off   [`RAB_N_SLICES];
  logic [3:0] s_flags [`RAB_N_SLICES];  // coherent, wr, rd, en
  logic       prio_c1_model;

  rab_lite_top DUT (.*);

  bind rab_resp_fsm rab_lite_chk u_chk (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #(CLK_PERIOD/2) Clk_CI = ~Clk_CI;
  end

  initial
  begin
    #((N_ROWS * 10 + 50) * CLK_PERIOD);
    $display("Timeout: no response from the DUT in time");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  task automatic set_row(input int i, input string name, input logic [1:0] chan,
                         input vaddr_t base, input vaddr_t span, input burst_len_t len,
                         input burst_size_t size, input logic typ, input logic [1:0] exp);
    row_name[i] = name;
    row_chan[i] = chan;
    row_base[i] = base;
    row_span[i] = span;
    row_len[i]  = len;
    row_size[i] = size;
    row_type[i] = typ;
    row_exp[i]  = exp;
  endtask

  task automatic cfg_write(input int addr, input cfg_word_t data);
    @(posedge Clk_CI);
    cfg_wen   <= 1'b1;
    cfg_addr  <= addr[`RAB_CFG_ADDR_W-1:0];
    cfg_wdata <= data;
  endtask

  function automatic vaddr_t pick_addr(input int i);
    if (row_span[i] == '0)
      return row_base[i];
    return row_base[i] + (($urandom % row_span[i]) & ~32'h7);  // 8 byte steps
  endfunction

  // last burst byte after aligning the start to the beat or bus width
  function automatic vaddr_t burst_last(input vaddr_t a, input burst_len_t len,
                                        input burst_size_t size);
    vaddr_t base;
    int     keep;
    base = a;
    keep = (size > `RAB_BUS_BYTES_LOG2) ? `RAB_BUS_BYTES_LOG2 : int'(size);
    for (int b = 0; b < keep; b++)
      base[b] = 1'b0;
    return base + (32'(len) + 32'd1) * (32'd1 << size) - 32'd1;
  endfunction

  task automatic model_lookup(input vaddr_t a, input burst_len_t len, input burst_size_t size,
                              output paddr_t pa, output logic coh);
    vaddr_t last;
    logic   found;
    last  = burst_last(a, len, size);
    found = 1'b0;
    pa    = '0;
    coh   = 1'b0;
    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      if (!found && s_flags[s][0] && s_start[s] <= a && last <= s_end[s])
      begin
        found = 1'b1;
        pa    = s_off[s] + paddr_t'(a - s_start[s]);
        coh   = s_flags[s][3];
      end
    end
  endtask

  task automatic wait_resp(output int ch);
    ch = 0;
    while (ch == 0)
    begin
      @(negedge Clk_CI);
      if (c1_accept || c1_drop)
        ch = 1;
      else if (c2_accept || c2_drop)
        ch = 2;
    end
  endtask

  task automatic check_resp(input int i, input int ch, input vaddr_t a);
    logic [5:0] exp_v;
    logic [5:0] act_v;
    logic [2:0] other_v;
    paddr_t     exp_addr;
    logic       exp_coh;
    case (row_exp[i])
      R_ACC:   exp_v = 6'b100000;  // accept, drop, miss, int miss/prot/multi
      R_PROT:  exp_v = 6'b010010;
      R_MISS:  exp_v = 6'b011100;
      default: exp_v = 6'b010001;
    endcase
    act_v = (ch == 1) ? {c1_accept, c1_drop, c1_miss, int_miss, int_prot, int_multi}
                      : {c2_accept, c2_drop, c2_miss, int_miss, int_prot, int_multi};
    other_v = (ch == 1) ? {c2_accept, c2_drop, c2_miss} : {c1_accept, c1_drop, c1_miss};
    assert (act_v == exp_v && other_v == 3'b000)
    else
    begin
      $display("Mismatch %s: expected %b/000, actual %b/%b", row_name[i], exp_v, act_v, other_v);
      $display("** FAIL **");
      $fatal(1, "wrong response strobes");
    end
    if (row_exp[i] == R_ACC)
    begin
      model_lookup(a, row_len[i], row_size[i], exp_addr, exp_coh);
      assert (out_addr == exp_addr && cache_coherent == exp_coh)
      else
      begin
        $display("Mismatch %s: expected %h/%b, actual %h/%b", row_name[i],
                 exp_addr, exp_coh, out_addr, cache_coherent);
        $display("** FAIL **");
        $fatal(1, "wrong translated address");
      end
    end
  endtask

  // requester takes valid away and pulses sent after an accept
  task automatic finish_req(input int ch, input logic acc, input int hold);
    @(posedge Clk_CI);
    if (ch == 1) c1_addr_valid <= 1'b0;
    else         c2_addr_valid <= 1'b0;
    if (acc)
    begin
      repeat (hold)
      begin
        @(negedge Clk_CI);
        assert (!(c1_accept | c1_drop | c2_accept | c2_drop))
        else
        begin
          $display("Response while the FSM waits for the sent strobe");
          $display("** FAIL **");
          $fatal(1, "missing back-pressure");
        end
        @(posedge Clk_CI);
      end
      if (ch == 1) c1_sent <= 1'b1;
      else         c2_sent <= 1'b1;
      @(posedge Clk_CI);
      c1_sent <= 1'b0;
      c2_sent <= 1'b0;
    end
  endtask

  task automatic run_row(input int i);
    vaddr_t a1;
    vaddr_t a2;
    int     first;
    int     second;
    int     exp_ch;
    logic   both;
    a1   = pick_addr(i);
    a2   = pick_addr(i);
    both = (row_chan[i] == 2'd3);
    @(posedge Clk_CI);
    if (row_chan[i] != 2'd2)
    begin
      c1_addr       <= a1;
      c1_len        <= row_len[i];
      c1_size       <= row_size[i];
      c1_type       <= row_type[i];
      c1_addr_valid <= 1'b1;
    end
    if (row_chan[i] != 2'd1)
    begin
      c2_addr       <= a2;
      c2_len        <= row_len[i];
      c2_size       <= row_size[i];
      c2_type       <= row_type[i];
      c2_addr_valid <= 1'b1;
    end
    wait_resp(first);
    exp_ch = both ? (prio_c1_model ? 1 : 2) : int'(row_chan[i]);
    assert (first == exp_ch)
    else
    begin
      $display("Mismatch %s: expected channel %0d, actual %0d", row_name[i], exp_ch, first);
      $display("** FAIL **");
      $fatal(1, "wrong channel served");
    end
    check_resp(i, first, (first == 1) ? a1 : a2);
    prio_c1_model = (first != 1);  // round robin hand over
    finish_req(first, row_exp[i] == R_ACC, both ? 3 : 0);
    if (both)
    begin
      wait_resp(second);
      assert (second != first)
      else
      begin
        $display("Mismatch %s: expected channel %0d, actual %0d", row_name[i], 3 - first, second);
        $display("** FAIL **");
        $fatal(1, "same channel served twice");
      end
      check_resp(i, second, (second == 1) ? a1 : a2);
      prio_c1_model = (second != 1);
      finish_req(second, row_exp[i] == R_ACC, 0);
    end
  endtask

  initial
  begin
    Rst_RBI       = 1'b0;
    cfg_wen       = 1'b0;
    cfg_addr      = '0;
    cfg_wdata     = '0;
    c1_addr       = '0;
    c1_len        = '0;
    c1_size       = '0;
    c1_type       = 1'b0;
    c1_addr_valid = 1'b0;
    c1_sent       = 1'b0;
    c2_addr       = '0;
    c2_len        = '0;
    c2_size       = '0;
    c2_type       = 1'b0;
    c2_addr_valid = 1'b0;
    c2_sent       = 1'b0;
    prio_c1_model = 1'b1;
    void'($urandom(32'hdd462e6b));

    s_start[0] = 32'h1000_0000;
    s_end[0]   = 32'h1000_FFFF;
    s_off[0]   = 40'h80_0000_0000;
    s_flags[0] = 4'hF;
    s_start[1] = 32'h2000_0000;
    s_end[1]   = 32'h2000_0FFF;
    s_off[1]   = 40'h12_3400_0000;
    s_flags[1] = 4'h3;  // read only
    s_start[2] = 32'h3000_0000;
    s_end[2]   = 32'h3000_FFFF;
    s_off[2]   = 40'h40_0000_0000;
    s_flags[2] = 4'h7;
    s_start[3] = 32'h3000_8000;  // overlaps the upper half of slice 2
    s_end[3]   = 32'h3001_7FFF;
    s_off[3]   = 40'h50_0000_0000;
    s_flags[3] = 4'h7;

    set_row(0, "rr_after_reset", 2'd3, 32'h1000_0000, 32'h8000, 8'd3, 3'd3, 1'b0, R_ACC);
    set_row(1, "read_slice0",    2'd1, 32'h1000_0100, 32'h4000, 8'd7, 3'd3, 1'b0, R_ACC);
    set_row(2, "rr_turn",        2'd3, 32'h1000_2000, 32'h1000, 8'd1, 3'd2, 1'b1, R_ACC);
    set_row(3, "burst_past_end", 2'd2, 32'h1000_FFF9, 32'h0,    8'd2, 3'd2, 1'b0, R_MISS);
    set_row(4, "write_slice1",   2'd1, 32'h2000_0000, 32'h800,  8'd3, 3'd3, 1'b1, R_PROT);
    set_row(5, "read_slice1",    2'd2, 32'h2000_0400, 32'h400,  8'd1, 3'd3, 1'b0, R_ACC);
    set_row(6, "overlap_23",     2'd1, 32'h3000_8000, 32'h4000, 8'd0, 3'd3, 1'b0, R_MULTI);
    set_row(7, "write_slice2",   2'd2, 32'h3000_0000, 32'h4000, 8'd3, 3'd3, 1'b1, R_ACC);
    set_row(8, "unmapped",       2'd1, 32'h5000_0000, 32'h1000, 8'd0, 3'd0, 1'b0, R_MISS);
    set_row(9, "rr_both_drop",   2'd3, 32'h2000_0000, 32'h800,  8'd0, 3'd3, 1'b1, R_PROT);

    repeat (2) @(posedge Clk_CI);
    Rst_RBI <= 1'b1;

    for (int s = 0; s < `RAB_N_SLICES; s++)
    begin
      cfg_write(s * 4 + 0, cfg_word_t'(s_start[s]));
      cfg_write(s * 4 + 1, cfg_word_t'(s_end[s]));
      cfg_write(s * 4 + 2, cfg_word_t'(s_off[s]));
      cfg_write(s * 4 + 3, cfg_word_t'(s_flags[s]));
    end
    @(posedge Clk_CI);
    cfg_wen <= 1'b0;

    for (int i = 0; i < N_ROWS; i++)
      run_row(i);

    repeat (2) @(posedge Clk_CI);
    $display("** PASS **");
    $finish;
  end

endmodule

/* rab_lite.f */
+incdir+hw
hw/rab_pkg.sv
hw/rab_cfg_regs.sv
hw/rab_req_arb.sv
hw/rab_slice_array.sv
hw/rab_resp_fsm.sv
hw/rab_lite_top.sv
tb/rab_lite_chk.sv
tb/rab_lite_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds rab_lite with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module rab_lite_tb \
  -f rab_lite.f -o rab_lite_sim > build.log 2>&1 \
  && ./obj_dir/rab_lite_sim > sim.log 2>&1
grep -q '^\*\* PASS \*\*$' sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
exit 0
